//--- logic/renamePkg.sv
`default_nettype none

package renamePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // architectural register file.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int RegNum = 32;
    localparam int NameW  = 5;
    localparam int DataW  = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reorder buffer and tags.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int RobDepth = 8;
    localparam int RobIdxW  = 3;

    // tag is slot index plus one, zero means ready.
    localparam int NickW = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fields passed through to dispatch.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int OpW   = 7;
    localparam int ImmW  = 32;
    localparam int AddrW = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue credits.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int CreditW = 4;

    // one credit per free slot.
    localparam logic [CreditW-1:0] FullCredit = CreditW'(RobDepth);

endpackage

`default_nettype wire

//--- logic/issueGate.sv
`default_nettype none
`timescale 1ns/10ps

module issueGate (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic issueValid,
    input  logic creditReturn,
    output logic issueReady,
    output logic issueTake
);

    logic [renamePkg::CreditW-1:0] credits;
    logic [renamePkg::CreditW-1:0] creditAdd;
    logic [renamePkg::CreditW-1:0] creditSub;

    assign issueReady = (credits != '0);

    // no issue is taken while the buffer is being emptied.
    assign issueTake = issueValid & issueReady & ~flush;

    assign creditAdd = {{(renamePkg::CreditW-1){1'b0}}, creditReturn};
    assign creditSub = {{(renamePkg::CreditW-1){1'b0}}, issueTake};

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= renamePkg::FullCredit;
        end else if (flush) begin
            credits <= renamePkg::FullCredit;
        end else begin
            // return and spend may land in the same cycle.
            credits <= credits + creditAdd - creditSub;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // reorder buffer never returns more credits than were spent.
    creditBounded: assert property (
        @(posedge clk) disable iff (rst)
        credits <= renamePkg::FullCredit
    ) else $error("issueGate: credit counter out of range");

endmodule

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none
`timescale 1ns/10ps

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,

    input  logic                         issueTake,
    input  logic [renamePkg::NameW-1:0]  issueRd,
    input  logic [renamePkg::NameW-1:0]  issueRs1,
    input  logic [renamePkg::NameW-1:0]  issueRs2,
    input  logic [renamePkg::OpW-1:0]    issueOp,
    input  logic [renamePkg::ImmW-1:0]   issueImm,
    input  logic [renamePkg::AddrW-1:0]  issuePc,
    input  logic [renamePkg::NickW-1:0]  allocNick,

    input  logic                         commitValid,
    input  logic [renamePkg::NameW-1:0]  commitRd,
    input  logic [renamePkg::DataW-1:0]  commitData,
    input  logic [renamePkg::NickW-1:0]  commitNick,

    output logic                         dispatchValid,
    output logic [renamePkg::NameW-1:0]  dispatchRd,
    output logic [renamePkg::OpW-1:0]    dispatchOp,
    output logic [renamePkg::ImmW-1:0]   dispatchImm,
    output logic [renamePkg::AddrW-1:0]  dispatchPc,
    output logic [renamePkg::DataW-1:0]  dispatchRs1Data,
    output logic [renamePkg::NickW-1:0]  dispatchRs1Nick,
    output logic [renamePkg::DataW-1:0]  dispatchRs2Data,
    output logic [renamePkg::NickW-1:0]  dispatchRs2Nick
);

    logic [renamePkg::DataW-1:0] regData [renamePkg::RegNum];
    logic [renamePkg::NickW-1:0] regNick [renamePkg::RegNum];
    logic                        rs1Hit;
    logic                        rs2Hit;

    // source retires in this very cycle and its tag still matches.
    function automatic logic srcHit(input logic [renamePkg::NameW-1:0] name);
        srcHit = commitValid && (commitRd == name) && (name != '0)
                 && (regNick[name] == commitNick);
    endfunction

    assign rs1Hit = srcHit(issueRs1);
    assign rs2Hit = srcHit(issueRs2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register and tag arrays.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < renamePkg::RegNum; i++) begin
                regData[i] <= '0;
                regNick[i] <= '0;
            end
        end else begin
            // a commit during flush is still written.
            if (commitValid && (commitRd != '0)) begin
                regData[commitRd] <= commitData;
                if (regNick[commitRd] == commitNick)
                    regNick[commitRd] <= '0;
            end
            if (flush) begin
                for (int i = 0; i < renamePkg::RegNum; i++)
                    regNick[i] <= '0;
            end else if (issueTake && (issueRd != '0)) begin
                // wins over a same-cycle clear.
                regNick[issueRd] <= allocNick;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dispatch register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst)
            dispatchValid <= 1'b0;
        else
            dispatchValid <= issueTake;
    end

    always_ff @(posedge clk) begin
        if (issueTake) begin
            dispatchRd      <= issueRd;
            dispatchOp      <= issueOp;
            dispatchImm     <= issueImm;
            dispatchPc      <= issuePc;
            dispatchRs1Data <= rs1Hit ? commitData : regData[issueRs1];
            dispatchRs1Nick <= rs1Hit ? '0 : regNick[issueRs1];
            dispatchRs2Data <= rs2Hit ? commitData : regData[issueRs2];
            dispatchRs2Nick <= rs2Hit ? '0 : regNick[issueRs2];
        end
    end

    // x0 is neither renamed nor written by retirement.
    zeroRegFixed: assert property (
        @(posedge clk) disable iff (rst)
        (regData[0] == '0) && (regNick[0] == '0)
    ) else $error("regFile: x0 was modified");

endmodule

`default_nettype wire

//--- logic/reorderBuffer.sv
`default_nettype none
`timescale 1ns/10ps

module reorderBuffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,

    input  logic                         issueTake,
    input  logic [renamePkg::NameW-1:0]  issueRd,
    output logic [renamePkg::NickW-1:0]  allocNick,

    input  logic                         wbValid,
    input  logic [renamePkg::NickW-1:0]  wbNick,
    input  logic [renamePkg::DataW-1:0]  wbData,

    output logic                         commitValid,
    output logic [renamePkg::NameW-1:0]  commitRd,
    output logic [renamePkg::DataW-1:0]  commitData,
    output logic [renamePkg::NickW-1:0]  commitNick,

    output logic                         creditReturn
);

    logic [renamePkg::NameW-1:0]    slotRd   [renamePkg::RobDepth];
    logic [renamePkg::DataW-1:0]    slotData [renamePkg::RobDepth];
    logic [renamePkg::RobDepth-1:0] slotBusy;
    logic [renamePkg::RobDepth-1:0] slotDone;
    logic [renamePkg::RobIdxW-1:0]  head;
    logic [renamePkg::RobIdxW-1:0]  tail;
    logic [renamePkg::NickW-1:0]    wbSlot;
    logic [renamePkg::RobIdxW-1:0]  wbIdx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tag <-> slot mapping.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign allocNick = {{(renamePkg::NickW-renamePkg::RobIdxW){1'b0}}, tail} + 1'b1;
    assign wbSlot    = wbNick - 1'b1;
    assign wbIdx     = wbSlot[renamePkg::RobIdxW-1:0];

    // head retires as soon as its result is in.
    assign commitValid = slotBusy[head] & slotDone[head];
    assign commitRd    = slotRd[head];
    assign commitData  = slotData[head];
    assign commitNick  = {{(renamePkg::NickW-renamePkg::RobIdxW){1'b0}}, head} + 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and slot state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            slotBusy     <= '0;
            slotDone     <= '0;
            creditReturn <= 1'b0;
        end else begin
            // the gate refills on flush by itself.
            creditReturn <= commitValid & ~flush;
            if (wbValid)
                slotDone[wbIdx] <= 1'b1;
            if (issueTake)
                slotDone[tail] <= 1'b0;
            if (flush) begin
                head     <= '0;
                tail     <= '0;
                slotBusy <= '0;
            end else begin
                if (commitValid) begin
                    slotBusy[head] <= 1'b0;
                    head           <= head + 1'b1;
                end
                if (issueTake) begin
                    slotBusy[tail] <= 1'b1;
                    tail           <= tail + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueTake)
            slotRd[tail] <= issueRd;
        if (wbValid)
            slotData[wbIdx] <= wbData;
    end

    // execution units only answer tags that are still in flight.
    wbToLiveSlot: assert property (
        @(posedge clk) disable iff (rst)
        wbValid |-> (wbNick != '0) && slotBusy[wbIdx]
    ) else $error("reorderBuffer: writeback to empty slot");

endmodule

`default_nettype wire

//--- logic/renameCore.sv
`default_nettype none
`timescale 1ns/10ps

module renameCore (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,

    input  logic                         issueValid,
    input  logic [renamePkg::NameW-1:0]  issueRd,
    input  logic [renamePkg::NameW-1:0]  issueRs1,
    input  logic [renamePkg::NameW-1:0]  issueRs2,
    input  logic [renamePkg::OpW-1:0]    issueOp,
    input  logic [renamePkg::ImmW-1:0]   issueImm,
    input  logic [renamePkg::AddrW-1:0]  issuePc,
    output logic                         issueReady,

    output logic                         dispatchValid,
    output logic [renamePkg::NameW-1:0]  dispatchRd,
    output logic [renamePkg::OpW-1:0]    dispatchOp,
    output logic [renamePkg::ImmW-1:0]   dispatchImm,
    output logic [renamePkg::AddrW-1:0]  dispatchPc,
    output logic [renamePkg::DataW-1:0]  dispatchRs1Data,
    output logic [renamePkg::NickW-1:0]  dispatchRs1Nick,
    output logic [renamePkg::DataW-1:0]  dispatchRs2Data,
    output logic [renamePkg::NickW-1:0]  dispatchRs2Nick,

    input  logic                         wbValid,
    input  logic [renamePkg::NickW-1:0]  wbNick,
    input  logic [renamePkg::DataW-1:0]  wbData,

    output logic                         commitValid,
    output logic [renamePkg::NameW-1:0]  commitRd,
    output logic [renamePkg::DataW-1:0]  commitData,
    output logic [renamePkg::NickW-1:0]  commitNick
);

    logic                        issueTake;
    logic                        creditReturn;
    logic [renamePkg::NickW-1:0] allocNick;

    issueGate i_issueGate (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .issueValid   (issueValid),
        .creditReturn (creditReturn),
        .issueReady   (issueReady),
        .issueTake    (issueTake)
    );

    regFile i_regFile (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .issueTake       (issueTake),
        .issueRd         (issueRd),
        .issueRs1        (issueRs1),
        .issueRs2        (issueRs2),
        .issueOp         (issueOp),
        .issueImm        (issueImm),
        .issuePc         (issuePc),
        .allocNick       (allocNick),
        .commitValid     (commitValid),
        .commitRd        (commitRd),
        .commitData      (commitData),
        .commitNick      (commitNick),
        .dispatchValid   (dispatchValid),
        .dispatchRd      (dispatchRd),
        .dispatchOp      (dispatchOp),
        .dispatchImm     (dispatchImm),
        .dispatchPc      (dispatchPc),
        .dispatchRs1Data (dispatchRs1Data),
        .dispatchRs1Nick (dispatchRs1Nick),
        .dispatchRs2Data (dispatchRs2Data),
        .dispatchRs2Nick (dispatchRs2Nick)
    );

    reorderBuffer i_reorderBuffer (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .issueTake    (issueTake),
        .issueRd      (issueRd),
        .allocNick    (allocNick),
        .wbValid      (wbValid),
        .wbNick       (wbNick),
        .wbData       (wbData),
        .commitValid  (commitValid),
        .commitRd     (commitRd),
        .commitData   (commitData),
        .commitNick   (commitNick),
        .creditReturn (creditReturn)
    );

endmodule

`default_nettype wire

//--- tests/renameChecks.svh
`ifndef RENAME_CHECKS_SVH
`define RENAME_CHECKS_SVH

int mismatchCount = 0;
int failCount     = 0;

task automatic checkData(
    input string                       name,
    input logic [renamePkg::DataW-1:0] got,
    input logic [renamePkg::DataW-1:0] expected
);
    if (got !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic checkNick(
    input string                       name,
    input logic [renamePkg::NickW-1:0] got,
    input logic [renamePkg::NickW-1:0] expected
);
    if (got !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic checkName(
    input string                       name,
    input logic [renamePkg::NameW-1:0] got,
    input logic [renamePkg::NameW-1:0] expected
);
    if (got !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("mismatch at %0t: %s is x%0d, expected x%0d", $time, name, got, expected);
    end
endtask

task automatic checkOp(
    input string                     name,
    input logic [renamePkg::OpW-1:0] got,
    input logic [renamePkg::OpW-1:0] expected
);
    if (got !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic checkFlag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        mismatchCount = mismatchCount + 1;
        $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, expected);
    end
endtask

task automatic reportFailure(input string what);
    failCount = failCount + 1;
    $display("error at %0t: %s", $time, what);
endtask

`endif

//--- tests/renameCoreTb.sv
`default_nettype none
`timescale 1ns/10ps

module renameCoreTb;

    // six directed tests, none longer than this.
    localparam int TestCount     = 6;
    localparam int CyclesPerTest = 40;
    localparam int CycleLimit    = TestCount * CyclesPerTest + 100;

    logic                         clk;
    logic                         rst;
    logic                         flush;
    logic                         issueValid;
    logic [renamePkg::NameW-1:0]  issueRd;
    logic [renamePkg::NameW-1:0]  issueRs1;
    logic [renamePkg::NameW-1:0]  issueRs2;
    logic [renamePkg::OpW-1:0]    issueOp;
    logic [renamePkg::ImmW-1:0]   issueImm;
    logic [renamePkg::AddrW-1:0]  issuePc;
    logic                         issueReady;
    logic                         dispatchValid;
    logic [renamePkg::NameW-1:0]  dispatchRd;
    logic [renamePkg::OpW-1:0]    dispatchOp;
    logic [renamePkg::ImmW-1:0]   dispatchImm;
    logic [renamePkg::AddrW-1:0]  dispatchPc;
    logic [renamePkg::DataW-1:0]  dispatchRs1Data;
    logic [renamePkg::NickW-1:0]  dispatchRs1Nick;
    logic [renamePkg::DataW-1:0]  dispatchRs2Data;
    logic [renamePkg::NickW-1:0]  dispatchRs2Nick;
    logic                         wbValid;
    logic [renamePkg::NickW-1:0]  wbNick;
    logic [renamePkg::DataW-1:0]  wbData;
    logic                         commitValid;
    logic [renamePkg::NameW-1:0]  commitRd;
    logic [renamePkg::DataW-1:0]  commitData;
    logic [renamePkg::NickW-1:0]  commitNick;

    int seed;
    int cycleCount = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [renamePkg::DataW-1:0]   archData  [renamePkg::RegNum];
    logic [renamePkg::NickW-1:0]   archNick  [renamePkg::RegNum];
    logic [renamePkg::NameW-1:0]   robRd     [renamePkg::RobDepth];
    logic [renamePkg::DataW-1:0]   robResult [renamePkg::RobDepth];
    logic                          robDone   [renamePkg::RobDepth];
    logic [renamePkg::RobIdxW-1:0] refHead;
    logic [renamePkg::RobIdxW-1:0] refTail;
    int                            refCount;
    int                            refCredits;
    logic                          returnPending;
    logic [renamePkg::NickW-1:0]   lastNick;
    logic [renamePkg::DataW-1:0]   keptData;

    `include "renameChecks.svh"

    renameCore i_renameCore (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit) begin
            $display("timeout: run stopped after %0d cycles, %0d mismatches, %0d other errors",
                     cycleCount, mismatchCount, failCount);
            $display("Finished with errors");
            $finish;
        end
    end

    // tag of a slot is its index plus one.
    function automatic logic [renamePkg::NickW-1:0] toNick(
        input logic [renamePkg::RobIdxW-1:0] idx
    );
        toNick = renamePkg::NickW'(idx) + renamePkg::NickW'(1);
    endfunction

    // one clock edge, applied to the model and checked against the DUT.
    task automatic tick();
        logic                          commitNow;
        logic                          take;
        logic                          hit1;
        logic                          hit2;
        logic [renamePkg::NickW-1:0]   headNick;
        logic [renamePkg::DataW-1:0]   exp1Data;
        logic [renamePkg::NickW-1:0]   exp1Nick;
        logic [renamePkg::DataW-1:0]   exp2Data;
        logic [renamePkg::NickW-1:0]   exp2Nick;
        logic [renamePkg::RobIdxW-1:0] wbSlot;
        commitNow = (refCount > 0) && robDone[refHead];
        take      = issueValid && (refCredits > 0) && !flush;
        headNick  = toNick(refHead);
        hit1 = commitNow && (issueRs1 != '0) && (issueRs1 == robRd[refHead])
               && (archNick[issueRs1] == headNick);
        hit2 = commitNow && (issueRs2 != '0) && (issueRs2 == robRd[refHead])
               && (archNick[issueRs2] == headNick);
        exp1Data = hit1 ? robResult[refHead] : archData[issueRs1];
        exp1Nick = hit1 ? '0 : archNick[issueRs1];
        exp2Data = hit2 ? robResult[refHead] : archData[issueRs2];
        exp2Nick = hit2 ? '0 : archNick[issueRs2];
        // retire first, so a rename of the same register at this edge wins.
        if (commitNow) begin
            if (robRd[refHead] != '0)
                archData[robRd[refHead]] = robResult[refHead];
            if (archNick[robRd[refHead]] == headNick)
                archNick[robRd[refHead]] = '0;
            refHead  = refHead + 1'b1;
            refCount = refCount - 1;
        end
        if (wbValid) begin
            wbSlot            = renamePkg::RobIdxW'(wbNick - 1'b1);
            robDone[wbSlot]   = 1'b1;
            robResult[wbSlot] = wbData;
        end
        lastNick = toNick(refTail);
        if (flush) begin
            for (int i = 0; i < renamePkg::RegNum; i++)
                archNick[i] = '0;
            refHead    = '0;
            refTail    = '0;
            refCount   = 0;
            refCredits = renamePkg::RobDepth;
        end else begin
            if (take) begin
                if (issueRd != '0)
                    archNick[issueRd] = lastNick;
                robRd[refTail]   = issueRd;
                robDone[refTail] = 1'b0;
                refTail          = refTail + 1'b1;
                refCount         = refCount + 1;
            end
            refCredits = refCredits + int'(returnPending) - int'(take);
        end
        returnPending = commitNow && !flush;
        @(posedge clk);
        @(negedge clk);
        checkFlag("dispatchValid", dispatchValid, take);
        if (take) begin
            checkName("dispatchRd", dispatchRd, issueRd);
            checkOp("dispatchOp", dispatchOp, issueOp);
            checkData("dispatchImm", dispatchImm, issueImm);
            checkData("dispatchPc", dispatchPc, issuePc);
            checkData("dispatchRs1Data", dispatchRs1Data, exp1Data);
            checkNick("dispatchRs1Nick", dispatchRs1Nick, exp1Nick);
            checkData("dispatchRs2Data", dispatchRs2Data, exp2Data);
            checkNick("dispatchRs2Nick", dispatchRs2Nick, exp2Nick);
        end
        checkFlag("issueReady", issueReady, refCredits > 0);
        checkFlag("commitValid", commitValid, (refCount > 0) && robDone[refHead]);
        if ((refCount > 0) && robDone[refHead]) begin
            checkName("commitRd", commitRd, robRd[refHead]);
            checkData("commitData", commitData, robResult[refHead]);
            checkNick("commitNick", commitNick, toNick(refHead));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic issue(
        input  logic [renamePkg::NameW-1:0] rd,
        input  logic [renamePkg::NameW-1:0] rs1,
        input  logic [renamePkg::NameW-1:0] rs2,
        output logic [renamePkg::NickW-1:0] nick
    );
        issueValid = 1'b1;
        issueRd    = rd;
        issueRs1   = rs1;
        issueRs2   = rs2;
        issueOp    = renamePkg::OpW'($random(seed));
        issueImm   = $random(seed);
        issuePc    = issuePc + 32'd4;
        tick();
        while (!dispatchValid)
            tick();
        nick       = lastNick;
        issueValid = 1'b0;
    endtask

    task automatic writeback(
        input logic [renamePkg::NickW-1:0] nick,
        input logic [renamePkg::DataW-1:0] data
    );
        wbValid = 1'b1;
        wbNick  = nick;
        wbData  = data;
        tick();
        wbValid = 1'b0;
    endtask

    task automatic retireWait(input logic [renamePkg::NickW-1:0] nick);
        while (!(commitValid && (commitNick == nick)))
            tick();
        tick();
    endtask

    // finish everything in flight, oldest first, and wait for the credits.
    task automatic drain();
        logic [renamePkg::RobIdxW-1:0] idx;
        idx = refHead;
        repeat (refCount) begin
            if (!robDone[idx])
                writeback(toNick(idx), $random(seed));
            idx = idx + 1'b1;
        end
        while ((refCount > 0) || (refCredits != renamePkg::RobDepth))
            tick();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic resetReadsTest();
        logic [renamePkg::NickW-1:0] nick;
        issue(5'd1, 5'd7, 5'd31, nick);
        checkData("dispatchRs1Data", dispatchRs1Data, '0);
        checkNick("dispatchRs1Nick", dispatchRs1Nick, '0);
        checkData("dispatchRs2Data", dispatchRs2Data, '0);
        checkNick("dispatchRs2Nick", dispatchRs2Nick, '0);
        drain();
    endtask

    task automatic renameTest();
        logic [renamePkg::NickW-1:0] nick;
        issue(5'd3, 5'd1, 5'd2, nick);
        issue(5'd4, 5'd3, 5'd0, nick);
        // slot 0 went to the first test, so x3 holds the tag of slot 1.
        checkNick("dispatchRs1Nick", dispatchRs1Nick, renamePkg::NickW'(2));
        issue(5'd3, 5'd0, 5'd3, nick);
        checkNick("dispatchRs2Nick", dispatchRs2Nick, renamePkg::NickW'(2));
        drain();
    endtask

    task automatic reverseRetireTest();
        logic [renamePkg::NickW-1:0] nicks   [3];
        logic [renamePkg::DataW-1:0] results [3];
        logic [renamePkg::NickW-1:0] nick;
        for (int i = 0; i < 3; i++) begin
            issue(renamePkg::NameW'(5 + i), 5'd0, 5'd0, nicks[i]);
            results[i] = $random(seed);
        end
        for (int i = 2; i >= 0; i--)
            writeback(nicks[i], results[i]);
        drain();
        keptData = results[0];
        issue(5'd8, 5'd5, 5'd6, nick);
        checkData("dispatchRs1Data", dispatchRs1Data, results[0]);
        checkNick("dispatchRs1Nick", dispatchRs1Nick, '0);
        checkData("dispatchRs2Data", dispatchRs2Data, results[1]);
        checkNick("dispatchRs2Nick", dispatchRs2Nick, '0);
        drain();
    endtask

    task automatic creditTest();
        logic [renamePkg::NickW-1:0] nicks [renamePkg::RobDepth];
        for (int i = 0; i < renamePkg::RobDepth; i++)
            issue(renamePkg::NameW'(16 + i), 5'd0, 5'd0, nicks[i]);
        checkFlag("issueReady", issueReady, 1'b0);
        issueValid = 1'b1;
        issueRd    = 5'd24;
        repeat (3) begin
            tick();
            if (dispatchValid)
                reportFailure("issue accepted with no credit left");
        end
        wbValid = 1'b1;
        wbNick  = nicks[0];
        wbData  = $random(seed);
        tick();
        wbValid = 1'b0;
        while (!dispatchValid)
            tick();
        issueValid = 1'b0;
        drain();
    endtask

    task automatic wawTest();
        logic [renamePkg::NickW-1:0] older;
        logic [renamePkg::NickW-1:0] newer;
        logic [renamePkg::NickW-1:0] nick;
        logic [renamePkg::DataW-1:0] olderData;
        logic [renamePkg::DataW-1:0] newerData;
        olderData = $random(seed);
        newerData = $random(seed);
        issue(5'd12, 5'd0, 5'd0, older);
        issue(5'd12, 5'd0, 5'd0, newer);
        writeback(older, olderData);
        retireWait(older);
        issue(5'd13, 5'd12, 5'd0, nick);
        checkNick("dispatchRs1Nick", dispatchRs1Nick, newer);
        checkData("dispatchRs1Data", dispatchRs1Data, olderData);
        writeback(newer, newerData);
        retireWait(newer);
        issue(5'd14, 5'd12, 5'd0, nick);
        checkNick("dispatchRs1Nick", dispatchRs1Nick, '0);
        checkData("dispatchRs1Data", dispatchRs1Data, newerData);
        drain();
    endtask

    task automatic flushTest();
        logic [renamePkg::NickW-1:0] nick;
        issue(5'd10, 5'd0, 5'd0, nick);
        issue(5'd11, 5'd0, 5'd0, nick);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        for (int i = 0; i < renamePkg::RobDepth; i++) begin
            checkFlag("issueReady", issueReady, 1'b1);
            issue(renamePkg::NameW'(16 + i), renamePkg::NameW'(10 + i % 2), 5'd5, nick);
            checkNick("dispatchRs1Nick", dispatchRs1Nick, '0);
            checkData("dispatchRs2Data", dispatchRs2Data, keptData);
        end
        drain();
    endtask

    initial begin
        seed       = 32'h39fe_55e6;
        clk        = 1'b0;
        rst        = 1'b1;
        flush      = 1'b0;
        issueValid = 1'b0;
        issueRd    = '0;
        issueRs1   = '0;
        issueRs2   = '0;
        issueOp    = 7'h33;
        issueImm   = '0;
        issuePc    = '0;
        wbValid    = 1'b0;
        wbNick     = '0;
        wbData     = '0;
        for (int i = 0; i < renamePkg::RegNum; i++) begin
            archData[i] = '0;
            archNick[i] = '0;
        end
        for (int i = 0; i < renamePkg::RobDepth; i++) begin
            robRd[i]     = '0;
            robResult[i] = '0;
            robDone[i]   = 1'b0;
        end
        refHead       = '0;
        refTail       = '0;
        refCount      = 0;
        refCredits    = renamePkg::RobDepth;
        returnPending = 1'b0;
        lastNick      = '0;
        keptData      = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkFlag("issueReady", issueReady, 1'b1);
        checkFlag("dispatchValid", dispatchValid, 1'b0);
        checkFlag("commitValid", commitValid, 1'b0);

        resetReadsTest();
        renameTest();
        reverseRetireTest();
        creditTest();
        wawTest();
        flushTest();

        $display("run complete: %0d mismatches, %0d other errors", mismatchCount, failCount);
        if ((mismatchCount == 0) && (failCount == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
logic/renamePkg.sv
logic/issueGate.sv
logic/regFile.sv
logic/reorderBuffer.sv
logic/renameCore.sv
tests/renameCoreTb.sv

//--- Makefile
SOURCES := $(wildcard logic/*.sv) tests/renameCoreTb.sv tests/renameChecks.svh sources.f

.PHONY: all run clean

all: run

obj_dir/renameCoreTb: $(SOURCES)
	verilator --binary --timing --assert --top-module renameCoreTb \
		-f sources.f -Mdir obj_dir -o renameCoreTb

run: obj_dir/renameCoreTb
	./obj_dir/renameCoreTb > sim.log
	cat sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
